/* Makefile */
# Verilator flow for the fetch stage

VERILATOR ?= verilator
FILELIST  ?= fetch_stage.f
TB_TOP    ?= fetch_stage_tb
RTL_TOP   ?= fetch_stage
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/fetch_ctrl.sv */
//////////////////////////////
// Fetch stage control
// Redirect versus consumption, mtvec init strobe
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl (
	input  wire                    pc_set_i,
	input  wire fetch_pkg::pc_mux_e pc_mux_i,
	input  wire                    req_i,
	input  wire                    halt_if_i,
	input  wire                    id_ready_i,
	input  wire                    fetch_valid_i,
	output logic                   branch_o,
	output logic                   fetch_ready_o,
	output logic                   if_valid_o,
	output logic                   csr_mtvec_init_o
);

	logic consume;

	// Redirect always wins
	assign branch_o = pc_set_i;

	// Head moves into IF/ID only when decode can take it
	// No move in a redirect cycle, the head is stale
	assign consume = fetch_valid_i
		& req_i
		& id_ready_i
		& ~halt_if_i
		& ~pc_set_i;

	// Pop of the buffer head
	assign fetch_ready_o = consume;

	// Load of the IF/ID register, same event
	assign if_valid_o = consume;

	// CSR file sets up mtvec on boot
	assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == fetch_pkg::PC_BOOT);

endmodule

`default_nettype wire

/* design/fetch_if_id_reg.sv */
//////////////////////////////
// IF/ID pipeline register
// Load has priority over clear
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetch_if_id_reg (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          if_valid_i,
	input  wire                          clear_instr_valid_i,
	input  wire [fetch_pkg::XLEN-1:0]    fetch_rdata_i,
	input  wire [fetch_pkg::XLEN-1:0]    fetch_addr_i,
	output logic                         instr_valid_id_o,
	output logic [fetch_pkg::XLEN-1:0]   instr_rdata_id_o,
	output logic [fetch_pkg::XLEN-1:0]   pc_id_o
);

	//////////////////////////////
	// Valid bit
	//////////////////////////////
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			instr_valid_id_o <= 1'b0;
		end
		else if (if_valid_i)
		begin
			instr_valid_id_o <= 1'b1;
		end
		else if (clear_instr_valid_i)
		begin
			// Data and PC stay, only valid drops
			instr_valid_id_o <= 1'b0;
		end
	end

	//////////////////////////////
	// Instruction and its PC
	//////////////////////////////
	always_ff @(posedge clk)
	begin
		// Frozen while decode stalls
		if (if_valid_i)
		begin
			instr_rdata_id_o <= fetch_rdata_i;
			pc_id_o          <= fetch_addr_i;
		end
	end

endmodule

`default_nettype wire

/* design/fetch_pc_select.sv */
//////////////////////////////
// Next fetch address selection
// Exception and interrupt vector forming
// Redirect target mux, word-aligned result
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetch_pc_select (
	input  wire fetch_pkg::pc_mux_e           pc_mux_i,
	input  wire fetch_pkg::exc_pc_mux_e       exc_pc_mux_i,
	input  wire [fetch_pkg::XLEN-1:0]         boot_addr_i,
	input  wire [fetch_pkg::XLEN-1:0]         jump_target_id_i,
	input  wire [fetch_pkg::XLEN-1:0]         jump_target_ex_i,
	input  wire [fetch_pkg::XLEN-1:0]         mepc_i,
	input  wire [fetch_pkg::XLEN-1:0]         depc_i,
	input  wire [fetch_pkg::XLEN-1:0]         dm_halt_addr_i,
	input  wire [fetch_pkg::XLEN-1:0]         dm_exception_addr_i,
	input  wire [fetch_pkg::XLEN-1:0]         pc_id_i,
	input  wire [fetch_pkg::TRAP_BASE_W-1:0]  m_trap_base_addr_i,
	input  wire [fetch_pkg::VEC_W-1:0]        m_exc_vec_pc_mux_i,
	output logic [fetch_pkg::XLEN-1:0]        branch_addr_o
);

	logic [fetch_pkg::XLEN-1:0] exc_pc;
	logic [fetch_pkg::XLEN-1:0] next_pc;

	//////////////////////////////
	// Exception target
	//////////////////////////////
	always_comb
	begin
		unique case (exc_pc_mux_i)
			// All synchronous exceptions share the table base
			fetch_pkg::EXC_PC_EXCEPTION: exc_pc = {m_trap_base_addr_i, 8'h00};
			// Vectored interrupts, one word per line
			fetch_pkg::EXC_PC_IRQ:       exc_pc = {m_trap_base_addr_i, 1'b0,
				m_exc_vec_pc_mux_i, 2'b00};
			// Debug module entry points
			fetch_pkg::EXC_PC_DBD:       exc_pc = {dm_halt_addr_i[fetch_pkg::XLEN-1:2], 2'b00};
			fetch_pkg::EXC_PC_DBE:       exc_pc = {dm_exception_addr_i[fetch_pkg::XLEN-1:2],
				2'b00};
			default:                     exc_pc = {m_trap_base_addr_i, 8'h00};
		endcase
	end

	//////////////////////////////
	// Redirect target
	//////////////////////////////
	always_comb
	begin
		unique case (pc_mux_i)
			fetch_pkg::PC_BOOT:      next_pc = boot_addr_i;
			fetch_pkg::PC_JUMP:      next_pc = jump_target_id_i;
			fetch_pkg::PC_BRANCH:    next_pc = jump_target_ex_i;
			fetch_pkg::PC_EXCEPTION: next_pc = exc_pc;
			// Return from trap handler
			fetch_pkg::PC_MRET:      next_pc = mepc_i;
			// Return from debug mode
			fetch_pkg::PC_DRET:      next_pc = depc_i;
			// Refetch from the instruction after FENCE.I
			fetch_pkg::PC_FENCEI:    next_pc = pc_id_i + fetch_pkg::INSTR_BYTES;
			default:                 next_pc = boot_addr_i;
		endcase
	end

	// Word-aligned fetch only
	assign branch_addr_o = {next_pc[fetch_pkg::XLEN-1:2], 2'b00};

endmodule

`default_nettype wire

/* design/fetch_pkg.sv */
//////////////////////////////
// Shared definitions for the instruction fetch stage
// Data and address widths, trap field widths
// Fetch step size, PC and exception-PC select enums
//////////////////////////////

`default_nettype none

package fetch_pkg;

	// Data and address width
	localparam int unsigned XLEN = 32;

	// Upper address bits of the trap vector table
	localparam int unsigned TRAP_BASE_W = 24;

	// Interrupt vector index width
	localparam int unsigned VEC_W = 5;

	// One fetch step, all instructions are 32-bit
	localparam logic [XLEN-1:0] INSTR_BYTES = XLEN'(4);

	// Redirect target select, driven by decode with pc_set_i
	typedef enum logic [2:0] {
		PC_BOOT      = 3'd0,
		PC_JUMP      = 3'd1,
		PC_BRANCH    = 3'd2,
		PC_EXCEPTION = 3'd3,
		PC_MRET      = 3'd4,
		PC_DRET      = 3'd5,
		PC_FENCEI    = 3'd6
	} pc_mux_e;

	// Exception target select, used with PC_EXCEPTION
	typedef enum logic [1:0] {
		EXC_PC_EXCEPTION = 2'd0,
		EXC_PC_IRQ       = 2'd1,
		EXC_PC_DBD       = 2'd2,
		EXC_PC_DBE       = 2'd3
	} exc_pc_mux_e;

endpackage

`default_nettype wire

/* design/fetch_prefetch_buffer.sv */
//////////////////////////////
// Prefetch buffer
// Memory request issue over req/gnt/rvalid
// Response FIFO with address tags, flush on redirect
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetch_prefetch_buffer #(
	parameter int unsigned FIFO_DEPTH = 4
) (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          req_i,
	input  wire                          branch_i,
	input  wire [fetch_pkg::XLEN-1:0]    branch_addr_i,
	input  wire                          fetch_ready_i,
	output logic                         fetch_valid_o,
	output logic [fetch_pkg::XLEN-1:0]   fetch_rdata_o,
	output logic [fetch_pkg::XLEN-1:0]   fetch_addr_o,
	output logic                         instr_req_o,
	output logic [fetch_pkg::XLEN-1:0]   instr_addr_o,
	input  wire                          instr_gnt_i,
	input  wire                          instr_rvalid_i,
	input  wire [fetch_pkg::XLEN-1:0]    instr_rdata_i
);

	localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);
	localparam int unsigned CNT_W = PTR_W + 1;
	localparam logic [CNT_W:0] DEPTH_L = (CNT_W+1)'(FIFO_DEPTH);

	// Fetch stream state
	logic                        active_q;
	logic                        req_pend_q;
	logic [fetch_pkg::XLEN-1:0]  fetch_addr_q;
	logic [fetch_pkg::XLEN-1:0]  resp_addr_q;

	// In-flight bookkeeping
	logic [CNT_W-1:0]            outstanding_q;
	logic [CNT_W-1:0]            discard_q;
	logic [CNT_W:0]              in_use;
	logic                        room;
	logic                        issued;
	logic                        drop_resp;

	// FIFO storage and pointers
	logic [fetch_pkg::XLEN-1:0]  data_mem [FIFO_DEPTH];
	logic [fetch_pkg::XLEN-1:0]  addr_mem [FIFO_DEPTH];
	logic [PTR_W-1:0]            wr_ptr_q;
	logic [PTR_W-1:0]            rd_ptr_q;
	logic [CNT_W-1:0]            count_q;
	logic                        push;
	logic                        pop;

	//////////////////////////////
	// Request side
	//////////////////////////////

	// Stored plus in-flight, flushed responses included
	assign in_use = {1'b0, count_q} + {1'b0, outstanding_q} + {1'b0, discard_q};
	assign room   = in_use < DEPTH_L;

	// Pending request held until granted
	assign instr_req_o  = active_q & ((req_i & room) | req_pend_q);
	assign instr_addr_o = fetch_addr_q;
	assign issued       = instr_req_o & instr_gnt_i;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			active_q   <= 1'b0;
			req_pend_q <= 1'b0;
		end
		else if (branch_i)
		begin
			// First redirect starts fetching
			active_q   <= 1'b1;
			req_pend_q <= 1'b0;
		end
		else
		begin
			req_pend_q <= instr_req_o & ~instr_gnt_i;
		end
	end

	// Next address to request and address of next kept response
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			fetch_addr_q <= '0;
			resp_addr_q  <= '0;
		end
		else if (branch_i)
		begin
			fetch_addr_q <= branch_addr_i;
			resp_addr_q  <= branch_addr_i;
		end
		else
		begin
			if (issued)
				fetch_addr_q <= fetch_addr_q + fetch_pkg::INSTR_BYTES;
			if (push)
				resp_addr_q <= resp_addr_q + fetch_pkg::INSTR_BYTES;
		end
	end

	//////////////////////////////
	// Response side
	//////////////////////////////

	// Responses of a flushed stream come first, in order
	assign drop_resp = instr_rvalid_i & (discard_q != '0);
	assign push      = instr_rvalid_i & ~drop_resp & ~branch_i;
	assign pop       = fetch_ready_i & fetch_valid_o;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			outstanding_q <= '0;
			discard_q     <= '0;
		end
		else if (branch_i)
		begin
			// Everything still in flight now belongs to the old stream
			outstanding_q <= '0;
			discard_q     <= discard_q + outstanding_q + CNT_W'(issued)
				- CNT_W'(instr_rvalid_i);
		end
		else
		begin
			outstanding_q <= outstanding_q + CNT_W'(issued)
				- CNT_W'(instr_rvalid_i & ~drop_resp);
			discard_q     <= discard_q - CNT_W'(drop_resp);
		end
	end

	// FIFO control
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end
		else if (branch_i)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr_q <= wr_ptr_q + PTR_W'(1);
			if (pop)
				rd_ptr_q <= rd_ptr_q + PTR_W'(1);
			count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
		end
	end

	// Data with its address tag
	always_ff @(posedge clk)
	begin
		if (push)
		begin
			data_mem[wr_ptr_q] <= instr_rdata_i;
			addr_mem[wr_ptr_q] <= resp_addr_q;
		end
	end

	// Oldest entry goes to the IF/ID register
	assign fetch_valid_o = count_q != '0;
	assign fetch_rdata_o = data_mem[rd_ptr_q];
	assign fetch_addr_o  = addr_mem[rd_ptr_q];

endmodule

`default_nettype wire

/* design/fetch_stage.sv */
//////////////////////////////
// Instruction fetch stage top
// PC select, prefetch buffer, control, IF/ID register
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
	parameter int unsigned FIFO_DEPTH = 4
) (
	input  wire                              clk,
	input  wire                              rst_n,

	// Control from decode
	input  wire                              req_i,
	input  wire                              pc_set_i,
	input  wire fetch_pkg::pc_mux_e          pc_mux_i,
	input  wire fetch_pkg::exc_pc_mux_e      exc_pc_mux_i,
	input  wire                              halt_if_i,
	input  wire                              id_ready_i,
	input  wire                              clear_instr_valid_i,

	// Redirect operands
	input  wire [fetch_pkg::XLEN-1:0]        boot_addr_i,
	input  wire [fetch_pkg::XLEN-1:0]        jump_target_id_i,
	input  wire [fetch_pkg::XLEN-1:0]        jump_target_ex_i,
	input  wire [fetch_pkg::XLEN-1:0]        mepc_i,
	input  wire [fetch_pkg::XLEN-1:0]        depc_i,
	input  wire [fetch_pkg::XLEN-1:0]        dm_halt_addr_i,
	input  wire [fetch_pkg::XLEN-1:0]        dm_exception_addr_i,
	input  wire [fetch_pkg::TRAP_BASE_W-1:0] m_trap_base_addr_i,
	input  wire [fetch_pkg::VEC_W-1:0]       m_exc_vec_pc_mux_i,

	// Instruction memory bus
	output logic                             instr_req_o,
	output logic [fetch_pkg::XLEN-1:0]       instr_addr_o,
	input  wire                              instr_gnt_i,
	input  wire                              instr_rvalid_i,
	input  wire [fetch_pkg::XLEN-1:0]        instr_rdata_i,

	// To decode
	output logic                             instr_valid_id_o,
	output logic [fetch_pkg::XLEN-1:0]       instr_rdata_id_o,
	output logic [fetch_pkg::XLEN-1:0]       pc_id_o,
	output logic                             csr_mtvec_init_o
);

	// Redirect path
	logic                        branch_req;
	logic [fetch_pkg::XLEN-1:0]  branch_addr;

	// Buffer head and handshake
	logic                        fetch_valid;
	logic                        fetch_ready;
	logic [fetch_pkg::XLEN-1:0]  fetch_rdata;
	logic [fetch_pkg::XLEN-1:0]  fetch_addr;
	logic                        if_valid;

	fetch_pc_select pc_select_i (
		.pc_mux_i            (pc_mux_i),
		.exc_pc_mux_i        (exc_pc_mux_i),
		.boot_addr_i         (boot_addr_i),
		.jump_target_id_i    (jump_target_id_i),
		.jump_target_ex_i    (jump_target_ex_i),
		.mepc_i              (mepc_i),
		.depc_i              (depc_i),
		.dm_halt_addr_i      (dm_halt_addr_i),
		.dm_exception_addr_i (dm_exception_addr_i),
		.pc_id_i             (pc_id_o),
		.m_trap_base_addr_i  (m_trap_base_addr_i),
		.m_exc_vec_pc_mux_i  (m_exc_vec_pc_mux_i),
		.branch_addr_o       (branch_addr)
	);

	fetch_prefetch_buffer #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) prefetch_buffer_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.req_i          (req_i),
		.branch_i       (branch_req),
		.branch_addr_i  (branch_addr),
		.fetch_ready_i  (fetch_ready),
		.fetch_valid_o  (fetch_valid),
		.fetch_rdata_o  (fetch_rdata),
		.fetch_addr_o   (fetch_addr),
		.instr_req_o    (instr_req_o),
		.instr_addr_o   (instr_addr_o),
		.instr_gnt_i    (instr_gnt_i),
		.instr_rvalid_i (instr_rvalid_i),
		.instr_rdata_i  (instr_rdata_i)
	);

	fetch_ctrl ctrl_i (
		.pc_set_i         (pc_set_i),
		.pc_mux_i         (pc_mux_i),
		.req_i            (req_i),
		.halt_if_i        (halt_if_i),
		.id_ready_i       (id_ready_i),
		.fetch_valid_i    (fetch_valid),
		.branch_o         (branch_req),
		.fetch_ready_o    (fetch_ready),
		.if_valid_o       (if_valid),
		.csr_mtvec_init_o (csr_mtvec_init_o)
	);

	fetch_if_id_reg if_id_reg_i (
		.clk                 (clk),
		.rst_n               (rst_n),
		.if_valid_i          (if_valid),
		.clear_instr_valid_i (clear_instr_valid_i),
		.fetch_rdata_i       (fetch_rdata),
		.fetch_addr_i        (fetch_addr),
		.instr_valid_id_o    (instr_valid_id_o),
		.instr_rdata_id_o    (instr_rdata_id_o),
		.pc_id_o             (pc_id_o)
	);

endmodule

`default_nettype wire

/* dv/fetch_stage_tb.sv */
//////////////////////////////
// Testbench for the fetch stage
// Memory model with random grant and response delays
// Reference PC model, consumption checks, test sequence
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetch_stage_tb;

	localparam int unsigned BOOT_CAP   = 100;
	localparam int unsigned STREAM_CAP = 2000;
	localparam int unsigned REDIR_CAP  = 3000;
	localparam int unsigned TRAP_CAP   = 4 * 200;
	localparam int unsigned STALL_CAP  = 2000;
	localparam int unsigned IDLE_CAP   = 300;
	localparam int unsigned TOTAL_CYC  = BOOT_CAP + STREAM_CAP + REDIR_CAP + TRAP_CAP
		+ STALL_CAP + IDLE_CAP;
	// Margin of three over the summed test lengths
	localparam real WATCHDOG_NS = TOTAL_CYC * 8.0 * 3.0;

	wire clk;
	wire rst_n;

	// DUT inputs
	logic                            req_i;
	logic                            pc_set_i;
	fetch_pkg::pc_mux_e              pc_mux_i;
	fetch_pkg::exc_pc_mux_e          exc_pc_mux_i;
	logic                            halt_if_i;
	logic                            id_ready_i;
	logic                            clear_instr_valid_i;
	logic [31:0]                     boot_addr_i;
	logic [31:0]                     jump_target_id_i;
	logic [31:0]                     jump_target_ex_i;
	logic [31:0]                     mepc_i;
	logic [31:0]                     depc_i;
	logic [31:0]                     dm_halt_addr_i;
	logic [31:0]                     dm_exception_addr_i;
	logic [fetch_pkg::TRAP_BASE_W-1:0] m_trap_base_addr_i;
	logic [fetch_pkg::VEC_W-1:0]     m_exc_vec_pc_mux_i;
	logic                            instr_gnt_i;
	logic                            instr_rvalid_i;
	logic [31:0]                     instr_rdata_i;

	// DUT outputs
	wire                             instr_req_o;
	wire [31:0]                      instr_addr_o;
	wire                             instr_valid_id_o;
	wire [31:0]                      instr_rdata_id_o;
	wire [31:0]                      pc_id_o;
	wire                             csr_mtvec_init_o;

	// Reference model and bookkeeping
	logic [31:0] exp_pc;
	int          cons_cnt;
	int          err_cnt;
	int          chk_cnt;
	logic        was_frozen;
	logic        was_hold;
	logic [31:0] prev_pc;
	logic [31:0] prev_data;
	logic        prev_valid;

	// Memory model state
	logic [31:0] resp_addr_q[$];
	int          resp_due_q[$];
	int          gnt_wait;
	int          mem_cyc;
	int          last_due;

	tb_clk_gen #(.PERIOD_NS(8), .RESET_CYCLES(4)) clk_gen_i (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	fetch_stage #(.FIFO_DEPTH(4)) dut_i (
		.clk                 (clk),
		.rst_n               (rst_n),
		.req_i               (req_i),
		.pc_set_i            (pc_set_i),
		.pc_mux_i            (pc_mux_i),
		.exc_pc_mux_i        (exc_pc_mux_i),
		.halt_if_i           (halt_if_i),
		.id_ready_i          (id_ready_i),
		.clear_instr_valid_i (clear_instr_valid_i),
		.boot_addr_i         (boot_addr_i),
		.jump_target_id_i    (jump_target_id_i),
		.jump_target_ex_i    (jump_target_ex_i),
		.mepc_i              (mepc_i),
		.depc_i              (depc_i),
		.dm_halt_addr_i      (dm_halt_addr_i),
		.dm_exception_addr_i (dm_exception_addr_i),
		.m_trap_base_addr_i  (m_trap_base_addr_i),
		.m_exc_vec_pc_mux_i  (m_exc_vec_pc_mux_i),
		.instr_req_o         (instr_req_o),
		.instr_addr_o        (instr_addr_o),
		.instr_gnt_i         (instr_gnt_i),
		.instr_rvalid_i      (instr_rvalid_i),
		.instr_rdata_i       (instr_rdata_i),
		.instr_valid_id_o    (instr_valid_id_o),
		.instr_rdata_id_o    (instr_rdata_id_o),
		.pc_id_o             (pc_id_o),
		.csr_mtvec_init_o    (csr_mtvec_init_o)
	);

	//////////////////////////////
	// Memory content and redirect rules
	//////////////////////////////

	// Fixed scramble of the whole address
	function automatic logic [31:0] mem_word(input logic [31:0] a);
		return {a[15:0] ^ 16'h5a3c, a[31:16]} ^ (a * 32'h9e37_79b9);
	endfunction

	// Target seen by the current pc_set_i
	function automatic logic [31:0] expected_target();
		logic [31:0] t;
		logic [31:0] base;
		base = {8'h00, m_trap_base_addr_i};
		case (pc_mux_i)
			fetch_pkg::PC_BOOT:   t = boot_addr_i;
			fetch_pkg::PC_JUMP:   t = jump_target_id_i;
			fetch_pkg::PC_BRANCH: t = jump_target_ex_i;
			fetch_pkg::PC_MRET:   t = mepc_i;
			fetch_pkg::PC_DRET:   t = depc_i;
			fetch_pkg::PC_FENCEI: t = pc_id_o + 32'd4;
			default:
			begin
				// Vector table sits on a 256 byte boundary
				case (exc_pc_mux_i)
					fetch_pkg::EXC_PC_IRQ: t = (base << 8) | (32'(m_exc_vec_pc_mux_i) << 2);
					fetch_pkg::EXC_PC_DBD: t = dm_halt_addr_i;
					fetch_pkg::EXC_PC_DBE: t = dm_exception_addr_i;
					default:               t = base << 8;
				endcase
			end
		endcase
		return t & ~32'h3;
	endfunction

	//////////////////////////////
	// Memory model
	//////////////////////////////
	always @(posedge clk or negedge rst_n)
	begin
		int d;
		int due;
		if (!rst_n)
		begin
			instr_gnt_i    <= 1'b0;
			instr_rvalid_i <= 1'b0;
			instr_rdata_i  <= '0;
			gnt_wait = 0;
			mem_cyc  = 0;
			last_due = 0;
			resp_addr_q.delete();
			resp_due_q.delete();
		end
		else
		begin
			mem_cyc++;
			if (instr_req_o && instr_gnt_i)
			begin
				// In order, one response per cycle at most
				d   = 1 + ($urandom % 3);
				due = mem_cyc + d - 1;
				if (due <= last_due)
					due = last_due + 1;
				last_due = due;
				resp_addr_q.push_back(instr_addr_o);
				resp_due_q.push_back(due);
				gnt_wait = $urandom % 3;
				instr_gnt_i <= (gnt_wait == 0);
			end
			else if (instr_req_o)
			begin
				if (gnt_wait > 0)
					gnt_wait--;
				instr_gnt_i <= (gnt_wait == 0);
			end
			instr_rvalid_i <= 1'b0;
			if (resp_due_q.size() > 0 && resp_due_q[0] <= mem_cyc)
			begin
				instr_rvalid_i <= 1'b1;
				instr_rdata_i  <= mem_word(resp_addr_q.pop_front());
				void'(resp_due_q.pop_front());
			end
		end
	end

	//////////////////////////////
	// Reference model and checks
	//////////////////////////////
	always @(posedge clk)
	begin
		if (rst_n)
		begin
			chk_cnt++;
			if (pc_set_i)
			begin
				assert (csr_mtvec_init_o == (pc_mux_i == fetch_pkg::PC_BOOT))
				else
				begin
					$display("error: csr_mtvec_init_o got %h expected %h", csr_mtvec_init_o,
						pc_mux_i == fetch_pkg::PC_BOOT);
					err_cnt++;
				end
				exp_pc <= expected_target();
			end
			else
			begin
				assert (!csr_mtvec_init_o)
				else
				begin
					$display("error: csr_mtvec_init_o got %h expected %h", csr_mtvec_init_o, 1'b0);
					err_cnt++;
				end
				if (instr_valid_id_o && id_ready_i && !halt_if_i)
				begin
					assert (pc_id_o === exp_pc)
					else
					begin
						$display("error: pc_id_o got %h expected %h", pc_id_o, exp_pc);
						err_cnt++;
					end
					assert (instr_rdata_id_o === mem_word(pc_id_o))
					else
					begin
						$display("error: instr_rdata_id_o got %h expected %h",
							instr_rdata_id_o, mem_word(pc_id_o));
						err_cnt++;
					end
					// Next instruction follows in sequence
					exp_pc   <= exp_pc + 32'd4;
					cons_cnt <= cons_cnt + 1;
				end
			end
			// A stalled edge must leave the IF/ID register alone
			if (was_frozen)
			begin
				assert (pc_id_o === prev_pc)
				else
				begin
					$display("error: pc_id_o got %h expected %h during stall", pc_id_o, prev_pc);
					err_cnt++;
				end
				assert (instr_rdata_id_o === prev_data)
				else
				begin
					$display("error: instr_rdata_id_o got %h expected %h during stall",
						instr_rdata_id_o, prev_data);
					err_cnt++;
				end
			end
			if (was_hold)
			begin
				assert (instr_valid_id_o === prev_valid)
				else
				begin
					$display("error: instr_valid_id_o got %h expected %h during stall",
						instr_valid_id_o, prev_valid);
					err_cnt++;
				end
			end
			was_frozen <= halt_if_i | ~id_ready_i;
			was_hold   <= (halt_if_i | ~id_ready_i) & ~pc_set_i;
			prev_pc    <= pc_id_o;
			prev_data  <= instr_rdata_id_o;
			prev_valid <= instr_valid_id_o;
		end
	end

	//////////////////////////////
	// Stimulus tasks
	//////////////////////////////

	// One cycle of decode-side inputs
	task automatic tick(input logic set, input fetch_pkg::pc_mux_e mux,
		input fetch_pkg::exc_pc_mux_e exc, input logic rdy, input logic hlt, input logic rq);
		logic [31:0] rnd_base;
		logic [31:0] rnd_vec;
		@(posedge clk);
		if (set)
		begin
			rnd_base = $urandom;
			rnd_vec  = $urandom;
			jump_target_id_i    <= $urandom;
			jump_target_ex_i    <= $urandom;
			mepc_i              <= $urandom;
			depc_i              <= $urandom;
			dm_halt_addr_i      <= $urandom;
			dm_exception_addr_i <= $urandom;
			m_trap_base_addr_i  <= rnd_base[fetch_pkg::TRAP_BASE_W-1:0];
			m_exc_vec_pc_mux_i  <= rnd_vec[fetch_pkg::VEC_W-1:0];
		end
		pc_set_i     <= set;
		pc_mux_i     <= mux;
		exc_pc_mux_i <= exc;
		id_ready_i   <= rdy;
		halt_if_i    <= hlt;
		req_i        <= rq;
		// Decode drops its instruction when it takes it or on redirect
		clear_instr_valid_i <= set | (rdy & ~hlt);
	endtask

	// Random operand cycles until n instructions are consumed
	task automatic run_until(input int n, input int cap, input bit redirects);
		fetch_pkg::pc_mux_e kinds[5];
		int start;
		int cyc;
		logic set;
		kinds[0] = fetch_pkg::PC_JUMP;
		kinds[1] = fetch_pkg::PC_BRANCH;
		kinds[2] = fetch_pkg::PC_MRET;
		kinds[3] = fetch_pkg::PC_DRET;
		kinds[4] = fetch_pkg::PC_FENCEI;
		start = cons_cnt;
		cyc   = 0;
		while (cons_cnt - start < n && cyc < cap)
		begin
			set = redirects && ($urandom % 16 == 0);
			tick(set, kinds[$urandom % 5], fetch_pkg::EXC_PC_EXCEPTION,
				($urandom % 4) != 0, 1'b0, 1'b1);
			cyc++;
		end
		assert (cons_cnt - start >= n)
		else
		begin
			$display("timeout: only %0d of %0d instructions consumed in %0d cycles",
				cons_cnt - start, n, cap);
			err_cnt++;
		end
	endtask

	task automatic report_test(input string name, input int err_before, input int cons_before);
		@(negedge clk);
		if (err_cnt == err_before)
			$display("test %s: ok, %0d consumed", name, cons_cnt - cons_before);
		else
			$display("test %s: failed with %0d errors", name, err_cnt - err_before);
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////
	initial
	begin
		int e0;
		int c0;
		int span;
		bit use_halt;
		void'($urandom(32'h9c50_66c3));
		req_i = 1'b1;
		pc_set_i = 1'b0;
		pc_mux_i = fetch_pkg::PC_BOOT;
		exc_pc_mux_i = fetch_pkg::EXC_PC_EXCEPTION;
		halt_if_i = 1'b0;
		id_ready_i = 1'b1;
		clear_instr_valid_i = 1'b0;
		boot_addr_i = 32'h0000_1a06;
		jump_target_id_i = '0;
		jump_target_ex_i = '0;
		mepc_i = '0;
		depc_i = '0;
		dm_halt_addr_i = '0;
		dm_exception_addr_i = '0;
		m_trap_base_addr_i = '0;
		m_exc_vec_pc_mux_i = '0;
		instr_gnt_i = 1'b0;
		instr_rvalid_i = 1'b0;
		instr_rdata_i = '0;
		exp_pc = '0;
		cons_cnt = 0;
		err_cnt = 0;
		chk_cnt = 0;
		was_frozen = 1'b0;
		was_hold = 1'b0;
		@(posedge rst_n);

		// Boot from an unaligned address
		e0 = err_cnt;
		c0 = cons_cnt;
		tick(1'b1, fetch_pkg::PC_BOOT, fetch_pkg::EXC_PC_EXCEPTION, 1'b1, 1'b0, 1'b1);
		run_until(1, BOOT_CAP, 1'b0);
		report_test("boot", e0, c0);

		// Plain sequential stream
		e0 = err_cnt;
		c0 = cons_cnt;
		run_until(200, STREAM_CAP, 1'b0);
		report_test("stream", e0, c0);

		e0 = err_cnt;
		c0 = cons_cnt;
		run_until(300, REDIR_CAP, 1'b1);
		report_test("redirect", e0, c0);

		// Each exception-PC select in turn
		e0 = err_cnt;
		c0 = cons_cnt;
		for (int k = 0; k < 4; k++)
		begin
			tick(1'b1, fetch_pkg::PC_EXCEPTION, fetch_pkg::exc_pc_mux_e'(k), 1'b1, 1'b0, 1'b1);
			run_until(3, TRAP_CAP / 4, 1'b0);
		end
		report_test("trap_vector", e0, c0);

		// Halt or decode back-pressure spans
		e0 = err_cnt;
		c0 = cons_cnt;
		for (int k = 0; k < 12; k++)
		begin
			span = 2 + ($urandom % 7);
			use_halt = ($urandom % 2) == 1;
			repeat (span)
				tick(1'b0, fetch_pkg::PC_JUMP, fetch_pkg::EXC_PC_EXCEPTION,
					use_halt, use_halt, 1'b1);
			run_until(3, STALL_CAP / 12, 1'b0);
		end
		report_test("stall", e0, c0);

		// Redirect while fetch is not requested
		e0 = err_cnt;
		tick(1'b1, fetch_pkg::PC_JUMP, fetch_pkg::EXC_PC_EXCEPTION, 1'b1, 1'b0, 1'b0);
		// Count settles after the edge
		@(negedge clk);
		c0 = cons_cnt;
		repeat (20)
			tick(1'b0, fetch_pkg::PC_JUMP, fetch_pkg::EXC_PC_EXCEPTION, 1'b1, 1'b0, 1'b0);
		@(negedge clk);
		assert (cons_cnt == c0 && !instr_req_o)
		else
		begin
			$display("instructions were fetched or consumed while req_i was low");
			err_cnt++;
		end
		run_until(4, IDLE_CAP, 1'b0);
		report_test("idle_request", e0, c0);

		@(negedge clk);
		$display("checks %0d, consumed %0d, errors %0d", chk_cnt, cons_cnt, err_cnt);
		if (err_cnt == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
//////////////////////////////
// Testbench clock and reset
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
	parameter int unsigned PERIOD_NS    = 8,
	parameter int unsigned RESET_CYCLES = 4
) (
	output logic clk_o,
	output logic rst_n_o
);

	initial
	begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
	end

	// Reset released away from the rising edge
	initial
	begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		rst_n_o = 1'b1;
	end

endmodule

`default_nettype wire

/* fetch_stage.f */
design/fetch_pkg.sv
design/fetch_pc_select.sv
design/fetch_prefetch_buffer.sv
design/fetch_ctrl.sv
design/fetch_if_id_reg.sv
design/fetch_stage.sv
dv/tb_clk_gen.sv
dv/fetch_stage_tb.sv
